//--- design/forth_params.svh
/*
 * stack processor parameters
 * cell and program address widths, stack depths, uart bit timing
 */
`ifndef FORTH_PARAMS_SVH
`define FORTH_PARAMS_SVH

// --------------------
// datapath
// one memory or stack word
`define CELL_W 32
// 256 program cells
`define ADDR_W 8

// --------------------
// stacks, both circular
`define DSTACK_DEPTH 16
`define RSTACK_DEPTH 8

// --------------------
// serial line
// clocks per bit, same for tx and rx
`define BAUD_DIV 16

`endif

//--- design/forth_isa_pkg.sv
/*
 * instruction set of the stack processor
 * cell and address types, opcode encoding, core phases
 */
`default_nettype none
`include "forth_params.svh"

package forth_isa_pkg;

	// one cell of program memory or stack
	typedef logic [`CELL_W-1:0] cell_t;
	typedef logic [`ADDR_W-1:0] addr_t;

	// --------------------
	// opcodes live in the low byte of a cell with bit 31 clear
	// bit 31 set means call to the negated cell value
	// anything not listed runs as a no-op, cell 0 included
	typedef enum logic [7:0] {
		op_lit         = 8'h01,
		op_plus        = 8'h02,
		op_minus       = 8'h03,
		op_and         = 8'h04,
		op_or          = 8'h05,
		op_not         = 8'h06,
		op_negate      = 8'h07,
		op_one_plus    = 8'h08,
		op_dup         = 8'h09,
		op_drop        = 8'h0a,
		op_over        = 8'h0b,
		op_equal       = 8'h0c,
		op_zero_equal  = 8'h0d,
		op_branch      = 8'h0e,
		op_zero_branch = 8'h0f,
		op_exit        = 8'h10,
		op_emit        = 8'h11,
		op_key         = 8'h12,
		op_led_on      = 8'h13,
		op_led_off     = 8'h14
	} op_e;

	// fetch/execute phases
	typedef enum logic [2:0] {
		fetch,
		execute,
		operand,
		wait_tx,
		wait_rx
	} core_state_e;

endpackage

`default_nettype wire

//--- design/forth_io_pkg.sv
/*
 * io channel types
 * program load port and uart byte handshakes
 */
`default_nettype none
`include "forth_params.svh"

package forth_io_pkg;

	// one program cell per clock while we is high
	typedef struct packed {
		logic                 we;
		forth_isa_pkg::addr_t addr;
		forth_isa_pkg::cell_t data;
	} load_t;

	// tx side: one-cycle request
	// rx side: level held until taken
	typedef struct packed {
		logic       stb;
		logic [7:0] data;
	} byte_chan_t;

endpackage

`default_nettype wire

//--- design/program_ram.sv
/*
 * program memory
 * one cell per address, registered read for the core,
 * write port for loading while the core is stopped
 */
`default_nettype none
`timescale 1ns/1ns
`include "forth_params.svh"

module program_ram (
	input wire clk,
	input wire forth_io_pkg::load_t load,
	input wire forth_isa_pkg::addr_t rd_addr,
	output forth_isa_pkg::cell_t rd_data
);

	forth_isa_pkg::cell_t mem [1 << `ADDR_W];

	// load write and core read share the array
	// data shows up one cycle after the address
	always_ff @(posedge clk) begin
		if (load.we) begin
			mem[load.addr] <= load.data;
		end
		rd_data <= mem[rd_addr];
	end

	// --------------------
	// core parks rd_addr at 0 while stopped
	// any load seen with another address means the core was running
	a_load_stopped: assert property (@(posedge clk) load.we |-> rd_addr == '0)
		else $error("program load while core is fetching");

endmodule

`default_nettype wire

//--- design/forth_core.sv
/*
 * inner interpreter
 * fetch/execute over program cells, circular data and return stacks,
 * uart emit/key handshakes and the led register
 */
`default_nettype none
`timescale 1ns/1ns
`include "forth_params.svh"

module forth_core (
	input wire clk,
	input wire reset,
	input wire run,
	output forth_isa_pkg::addr_t rd_addr,
	input wire forth_isa_pkg::cell_t rd_data,
	output forth_io_pkg::byte_chan_t tx_req,
	input wire tx_busy,
	input wire forth_io_pkg::byte_chan_t rx_byte,
	output logic rx_take,
	output logic [2:0] led
);

	localparam int DW = $clog2(`DSTACK_DEPTH);
	localparam int RW = $clog2(`RSTACK_DEPTH);

	forth_isa_pkg::core_state_e state, state_n;
	forth_isa_pkg::op_e op_q, op_n, cur_op;
	forth_isa_pkg::addr_t pc, pc_n, pc_inc, pc_skip, call_target;
	forth_isa_pkg::cell_t call_neg;
	logic [2:0] led_n;

	// data stack, dp counts entries, low bits index the array
	forth_isa_pkg::cell_t dstack [`DSTACK_DEPTH];
	logic [DW:0] dp, dp_n, dp_m1, dp_m2;
	forth_isa_pkg::cell_t tos, nos, ds_wd;
	logic ds_we;
	logic [DW-1:0] ds_wa;

	// return stack holds addresses only
	forth_isa_pkg::addr_t rstack [`RSTACK_DEPTH];
	logic [RW-1:0] rp, rp_n, rp_m1;
	logic rs_we;

	assign cur_op = forth_isa_pkg::op_e'(rd_data[7:0]);
	assign pc_inc = pc + 1'b1;
	assign pc_skip = pc + 2'd2;
	// call cell is the negated target
	assign call_neg = -rd_data;
	assign call_target = call_neg[`ADDR_W-1:0];
	assign dp_m1 = dp - 1'b1;
	assign dp_m2 = dp - 2'd2;
	assign rp_m1 = rp - 1'b1;
	assign tos = dstack[dp_m1[DW-1:0]];
	assign nos = dstack[dp_m2[DW-1:0]];

	// execute already reads the operand cell after the opcode
	assign rd_addr = !run ? '0 : (state == forth_isa_pkg::execute) ? pc_inc : pc;

	// --------------------
	// next-state and stack write decode
	always_comb begin
		state_n = state;
		op_n = op_q;
		pc_n = pc;
		dp_n = dp;
		rp_n = rp;
		led_n = led;
		ds_we = 1'b0;
		ds_wa = dp[DW-1:0];
		ds_wd = rd_data;
		rs_we = 1'b0;
		rx_take = 1'b0;
		tx_req = '{stb: 1'b0, data: tos[7:0]};
		case (state)
			forth_isa_pkg::fetch: state_n = forth_isa_pkg::execute;
			forth_isa_pkg::execute: begin
				op_n = cur_op;
				pc_n = pc_inc;
				state_n = forth_isa_pkg::fetch;
				if (rd_data[`CELL_W-1]) begin
					// call, return address is the next cell
					rs_we = 1'b1;
					rp_n = rp + 1'b1;
					pc_n = call_target;
				end else begin
					case (cur_op)
						forth_isa_pkg::op_lit,
						forth_isa_pkg::op_branch,
						forth_isa_pkg::op_zero_branch: begin
							pc_n = pc;
							state_n = forth_isa_pkg::operand;
						end
						// two in, one out
						forth_isa_pkg::op_plus,
						forth_isa_pkg::op_minus,
						forth_isa_pkg::op_and,
						forth_isa_pkg::op_or,
						forth_isa_pkg::op_equal: begin
							ds_we = 1'b1;
							ds_wa = dp_m2[DW-1:0];
							dp_n = dp_m1;
							case (cur_op)
								forth_isa_pkg::op_plus: ds_wd = nos + tos;
								forth_isa_pkg::op_minus: ds_wd = nos - tos;
								forth_isa_pkg::op_and: ds_wd = nos & tos;
								forth_isa_pkg::op_or: ds_wd = nos | tos;
								default: ds_wd = (nos == tos) ? '1 : '0;
							endcase
						end
						// top rewritten in place
						forth_isa_pkg::op_not,
						forth_isa_pkg::op_negate,
						forth_isa_pkg::op_one_plus,
						forth_isa_pkg::op_zero_equal: begin
							ds_we = 1'b1;
							ds_wa = dp_m1[DW-1:0];
							case (cur_op)
								forth_isa_pkg::op_not: ds_wd = ~tos;
								forth_isa_pkg::op_negate: ds_wd = -tos;
								forth_isa_pkg::op_one_plus: ds_wd = tos + 1'b1;
								default: ds_wd = (tos == '0) ? '1 : '0;
							endcase
						end
						forth_isa_pkg::op_dup: begin
							ds_we = 1'b1;
							ds_wd = tos;
							dp_n = dp + 1'b1;
						end
						forth_isa_pkg::op_over: begin
							ds_we = 1'b1;
							ds_wd = nos;
							dp_n = dp + 1'b1;
						end
						forth_isa_pkg::op_drop: dp_n = dp_m1;
						forth_isa_pkg::op_exit: begin
							pc_n = rstack[rp_m1];
							rp_n = rp_m1;
						end
						forth_isa_pkg::op_emit: begin
							// transmitter still busy, refetch the same cell
							if (tx_busy) begin
								pc_n = pc;
							end else begin
								tx_req.stb = 1'b1;
								dp_n = dp_m1;
								state_n = forth_isa_pkg::wait_tx;
							end
						end
						forth_isa_pkg::op_key: state_n = forth_isa_pkg::wait_rx;
						forth_isa_pkg::op_led_on: led_n = 3'd7;
						forth_isa_pkg::op_led_off: led_n = '0;
						default: ;
					endcase
				end
			end
			// rd_data now holds the cell after the opcode
			forth_isa_pkg::operand: begin
				pc_n = pc_skip;
				state_n = forth_isa_pkg::fetch;
				case (op_q)
					forth_isa_pkg::op_lit: begin
						ds_we = 1'b1;
						dp_n = dp + 1'b1;
					end
					forth_isa_pkg::op_branch: pc_n = rd_data[`ADDR_W-1:0];
					forth_isa_pkg::op_zero_branch: begin
						dp_n = dp_m1;
						if (tos == '0) begin
							pc_n = rd_data[`ADDR_W-1:0];
						end
					end
					default: ;
				endcase
			end
			// busy rose right after the strobe, wait for the stop bit
			forth_isa_pkg::wait_tx: begin
				if (!tx_busy) begin
					state_n = forth_isa_pkg::fetch;
				end
			end
			forth_isa_pkg::wait_rx: begin
				if (rx_byte.stb) begin
					rx_take = 1'b1;
					ds_we = 1'b1;
					ds_wd = forth_isa_pkg::cell_t'(rx_byte.data);
					dp_n = dp + 1'b1;
					state_n = forth_isa_pkg::fetch;
				end
			end
			default: state_n = forth_isa_pkg::fetch;
		endcase
	end

	// --------------------
	// control registers, held at address 0 while stopped
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= forth_isa_pkg::fetch;
			op_q <= forth_isa_pkg::op_lit;
			pc <= '0;
			dp <= '0;
			rp <= '0;
			led <= '0;
		end else if (!run) begin
			state <= forth_isa_pkg::fetch;
			pc <= '0;
			dp <= '0;
			rp <= '0;
		end else begin
			state <= state_n;
			op_q <= op_n;
			pc <= pc_n;
			dp <= dp_n;
			rp <= rp_n;
			led <= led_n;
		end
	end

	// stack storage
	always_ff @(posedge clk) begin
		if (ds_we) begin
			dstack[ds_wa] <= ds_wd;
		end
		if (rs_we) begin
			rstack[rp] <= pc_inc;
		end
	end

	// --------------------
	// underflow shows up as a huge count
	a_dstack_bounds: assert property (@(posedge clk) disable iff (!reset)
		dp <= `DSTACK_DEPTH)
		else $error("data stack pointer wrapped");

	// request only into an idle transmitter, which goes busy next cycle
	a_tx_handshake: assert property (@(posedge clk) disable iff (!reset)
		tx_req.stb |-> !tx_busy ##1 tx_busy)
		else $error("emit strobe while transmitter busy");

endmodule

`default_nettype wire

//--- design/uart_tx.sv
/*
 * uart transmitter
 * start bit, 8 data bits lsb first, stop bit, busy for the whole frame
 */
`default_nettype none
`timescale 1ns/1ns
`include "forth_params.svh"

module uart_tx (
	input wire clk,
	input wire reset,
	input wire forth_io_pkg::byte_chan_t tx_req,
	output logic tx_busy,
	output logic tx
);

	localparam int CW = $clog2(`BAUD_DIV);

	logic [CW-1:0] baud_cnt;
	// bits already on the line, start bit is 0
	logic [3:0] bit_cnt;
	// data then stop bit
	logic [8:0] shreg;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			tx_busy <= 1'b0;
			tx <= 1'b1;
			baud_cnt <= '0;
			bit_cnt <= '0;
		end else if (!tx_busy) begin
			// start bit goes out right away
			if (tx_req.stb) begin
				tx_busy <= 1'b1;
				tx <= 1'b0;
				shreg <= {1'b1, tx_req.data};
				baud_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (baud_cnt == CW'(`BAUD_DIV - 1)) begin
			baud_cnt <= '0;
			if (bit_cnt == 4'd9) begin
				// stop bit done, 10 bit times after the request
				tx_busy <= 1'b0;
				tx <= 1'b1;
			end else begin
				tx <= shreg[0];
				shreg <= shreg >> 1;
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	// line idles high
	a_tx_idle: assert property (@(posedge clk) disable iff (!reset) !tx_busy |-> tx)
		else $error("tx low while idle");

endmodule

`default_nettype wire

//--- design/uart_rx.sv
/*
 * uart receiver
 * finds the start edge, samples mid-bit, holds the byte until taken
 */
`default_nettype none
`timescale 1ns/1ns
`include "forth_params.svh"

module uart_rx (
	input wire clk,
	input wire reset,
	input wire rx,
	input wire rx_take,
	output forth_io_pkg::byte_chan_t rx_byte
);

	localparam int CW = $clog2(`BAUD_DIV);

	logic rx_q;
	logic busy;
	logic stb_q;
	// countdown to the next mid-bit sample
	logic [CW-1:0] baud_cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0] bit_cnt;
	logic [7:0] shreg;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rx_q <= 1'b1;
			busy <= 1'b0;
			stb_q <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			rx_q <= rx;
			if (stb_q) begin
				// byte held, anything arriving now is dropped
				if (rx_take) begin
					stb_q <= 1'b0;
				end
			end else if (!busy) begin
				if (rx_q && !rx) begin
					busy <= 1'b1;
					baud_cnt <= CW'(`BAUD_DIV / 2 - 1);
					bit_cnt <= '0;
				end
			end else if (baud_cnt != '0) begin
				baud_cnt <= baud_cnt - 1'b1;
			end else begin
				baud_cnt <= CW'(`BAUD_DIV - 1);
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 4'd0) begin
					// glitch, not a real start bit
					if (rx) begin
						busy <= 1'b0;
					end
				end else if (bit_cnt == 4'd9) begin
					// middle of the stop bit
					busy <= 1'b0;
					stb_q <= 1'b1;
				end else begin
					shreg <= {rx, shreg[7:1]};
				end
			end
		end
	end

	assign rx_byte = '{stb: stb_q, data: shreg};

endmodule

`default_nettype wire

//--- design/forth_top.sv
/*
 * stack processor top
 * program memory, core and uart pair
 */
`default_nettype none
`timescale 1ns/1ns
`include "forth_params.svh"

module forth_top (
	input wire clk,
	input wire reset,
	input wire run,
	input wire forth_io_pkg::load_t load,
	input wire rx,
	output logic tx,
	output logic [2:0] led
);

	// core to memory
	forth_isa_pkg::addr_t rd_addr;
	forth_isa_pkg::cell_t rd_data;
	// core to uart
	forth_io_pkg::byte_chan_t tx_req;
	forth_io_pkg::byte_chan_t rx_byte;
	logic tx_busy;
	logic rx_take;

	program_ram program_ram_i (
		.clk     (clk),
		.load    (load),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	forth_core forth_core_i (
		.clk     (clk),
		.reset   (reset),
		.run     (run),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.tx_req  (tx_req),
		.tx_busy (tx_busy),
		.rx_byte (rx_byte),
		.rx_take (rx_take),
		.led     (led)
	);

	uart_tx uart_tx_i (
		.clk     (clk),
		.reset   (reset),
		.tx_req  (tx_req),
		.tx_busy (tx_busy),
		.tx      (tx)
	);

	uart_rx uart_rx_i (
		.clk     (clk),
		.reset   (reset),
		.rx      (rx),
		.rx_take (rx_take),
		.rx_byte (rx_byte)
	);

endmodule

`default_nettype wire

//--- verification/forth_tb.sv
/*
 * stack processor testbench
 * loads small programs, runs them, decodes the serial output
 * and compares every byte with a reference model
 */
`default_nettype none
`timescale 1ns/1ns
`include "forth_params.svh"

module forth_tb;

	localparam int frame_cycles = 10 * `BAUD_DIV;
	// longest gap before a start bit shows up
	localparam int idle_limit = 4 * frame_cycles;

	logic clk;
	logic reset;
	logic run;
	forth_io_pkg::load_t load;
	logic rx;
	logic tx;
	logic [2:0] led;

	integer seed;
	int errors;
	int bytes_seen;
	int loops;
	int sub_addr;
	forth_isa_pkg::cell_t prog [$];
	// decoded from tx, and what the model says should come out
	logic [7:0] tx_q [$];
	logic [7:0] exp_q [$];
	logic [7:0] tx_byte;
	logic [7:0] exp_byte;
	logic [7:0] k;
	logic [7:0] mark;
	forth_isa_pkg::cell_t a, b, r;
	forth_isa_pkg::op_e op1, op2;

	forth_top forth_top_i (
		.clk   (clk),
		.reset (reset),
		.run   (run),
		.load  (load),
		.rx    (rx),
		.tx    (tx),
		.led   (led)
	);

	always #20 clk = ~clk;

	// --------------------
	// reference model, a is next on stack, b is top
	function automatic forth_isa_pkg::cell_t ref_result(input forth_isa_pkg::op_e op,
			input forth_isa_pkg::cell_t a, input forth_isa_pkg::cell_t b);
		case (op)
			forth_isa_pkg::op_plus: return a + b;
			forth_isa_pkg::op_minus: return a - b;
			forth_isa_pkg::op_and: return a & b;
			forth_isa_pkg::op_or: return a | b;
			// unary ones only look at a
			forth_isa_pkg::op_not: return ~a;
			forth_isa_pkg::op_negate: return -a;
			forth_isa_pkg::op_one_plus: return a + 32'd1;
			// flags are all ones or zero
			forth_isa_pkg::op_equal: return (a == b) ? '1 : '0;
			forth_isa_pkg::op_zero_equal: return (a == '0) ? '1 : '0;
			default: return a;
		endcase
	endfunction

	// program building
	task automatic put_op(input forth_isa_pkg::op_e op);
		prog.push_back(forth_isa_pkg::cell_t'(op));
	endtask

	// lit, branch and zero_branch carry a second cell
	task automatic put_operand(input forth_isa_pkg::op_e op, input forth_isa_pkg::cell_t value);
		prog.push_back(forth_isa_pkg::cell_t'(op));
		prog.push_back(value);
	endtask

	// branch to itself, program parks here
	task automatic end_in_self_loop();
		int here;
		here = prog.size();
		put_operand(forth_isa_pkg::op_branch, forth_isa_pkg::cell_t'(here));
	endtask

	// --------------------
	// stop the core, write all cells, start from address 0
	task automatic load_program();
		@(posedge clk);
		#5;
		run = 1'b0;
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clk);
			#5;
			load = '{we: 1'b1, addr: forth_isa_pkg::addr_t'(i), data: prog[i]};
		end
		@(posedge clk);
		#5;
		load.we = 1'b0;
		run = 1'b1;
	endtask

	// sample tx at mid-bit on falling clock edges
	task automatic decode_frames(input int count);
		int waited;
		logic [7:0] value;
		repeat (count) begin
			waited = 0;
			while (tx === 1'b1 && waited < idle_limit) begin
				@(negedge clk);
				waited++;
			end
			if (tx !== 1'b0) begin
				$display("no start bit on tx within %0d cycles", idle_limit);
				errors++;
				return;
			end
			// centre of the start bit
			repeat (`BAUD_DIV / 2) @(negedge clk);
			for (int i = 0; i < 8; i++) begin
				repeat (`BAUD_DIV) @(negedge clk);
				value[i] = tx;
			end
			repeat (`BAUD_DIV) @(negedge clk);
			if (tx !== 1'b1) begin
				$display("stop bit missing on tx");
				errors++;
			end
			tx_q.push_back(value);
		end
	endtask

	// one frame on rx, lsb first
	task automatic send_byte(input logic [7:0] value);
		logic [9:0] frame;
		frame = {1'b1, value, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			#5;
			rx = frame[i];
			repeat (`BAUD_DIV - 1) @(posedge clk);
		end
	endtask

	task automatic start_program(input int count);
		load_program();
		fork
			decode_frames(count);
		join_none
	endtask

	// done once every expected byte went through the compare
	task automatic wait_drained(input int limit);
		int waited;
		waited = 0;
		while ((exp_q.size() != 0 || tx_q.size() != 0) && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("timed out after %0d cycles, %0d bytes never came", limit, exp_q.size());
			errors++;
			exp_q.delete();
		end
	endtask

	task automatic wait_led(input logic [2:0] value, input int limit);
		int waited;
		waited = 0;
		while (led !== value && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (led !== value) begin
			$display("led did not change to %0d within %0d cycles", value, limit);
			errors++;
		end
	endtask

	// a start bit in this window is one more marker
	task automatic check_quiet(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			if (tx !== 1'b1) begin
				bytes_seen++;
				return;
			end
		end
	endtask

	// --------------------
	// compare process
	always @(negedge clk) begin
		if (tx_q.size() != 0) begin
			tx_byte = tx_q.pop_front();
			bytes_seen++;
			assert (exp_q.size() != 0)
			else begin
				$display("byte %h came out on tx with nothing expected", tx_byte);
				errors++;
			end
			if (exp_q.size() != 0) begin
				exp_byte = exp_q.pop_front();
				assert (tx_byte == exp_byte)
				else begin
					$display("FAILED tx_byte expected %h got %h", exp_byte, tx_byte);
					errors++;
				end
			end
		end
	end

	initial begin
		seed = 32'h4a85;
		errors = 0;
		bytes_seen = 0;
		clk = 1'b0;
		reset = 1'b0;
		run = 1'b0;
		load = '0;
		rx = 1'b1;
		repeat (3) @(posedge clk);
		#5;
		reset = 1'b1;

		// --------------------
		// arithmetic then a unary op on random pairs
		for (int t = 0; t < 8; t++) begin
			a = $random(seed);
			b = $random(seed);
			case (t % 4)
				0: op1 = forth_isa_pkg::op_plus;
				1: op1 = forth_isa_pkg::op_minus;
				2: op1 = forth_isa_pkg::op_and;
				default: op1 = forth_isa_pkg::op_or;
			endcase
			case (t % 3)
				0: op2 = forth_isa_pkg::op_not;
				1: op2 = forth_isa_pkg::op_negate;
				default: op2 = forth_isa_pkg::op_one_plus;
			endcase
			prog.delete();
			put_operand(forth_isa_pkg::op_lit, a);
			put_operand(forth_isa_pkg::op_lit, b);
			put_op(op1);
			put_op(op2);
			put_op(forth_isa_pkg::op_emit);
			end_in_self_loop();
			r = ref_result(op2, ref_result(op1, a, b), '0);
			exp_q.push_back(r[7:0]);
			start_program(1);
			wait_drained(2 * frame_cycles);
		end

		// stack shuffles and flags, one equal pair on the second pass
		for (int t = 0; t < 3; t++) begin
			a = $random(seed);
			b = (t == 1) ? a : $random(seed);
			prog.delete();
			put_operand(forth_isa_pkg::op_lit, a);
			put_op(forth_isa_pkg::op_dup);
			put_op(forth_isa_pkg::op_equal);
			put_op(forth_isa_pkg::op_emit);
			r = ref_result(forth_isa_pkg::op_equal, a, a);
			exp_q.push_back(r[7:0]);
			// a b a on the stack, emitted top first
			put_operand(forth_isa_pkg::op_lit, a);
			put_operand(forth_isa_pkg::op_lit, b);
			put_op(forth_isa_pkg::op_over);
			put_op(forth_isa_pkg::op_emit);
			put_op(forth_isa_pkg::op_emit);
			put_op(forth_isa_pkg::op_emit);
			exp_q.push_back(a[7:0]);
			exp_q.push_back(b[7:0]);
			exp_q.push_back(a[7:0]);
			put_operand(forth_isa_pkg::op_lit, a);
			put_operand(forth_isa_pkg::op_lit, b);
			put_op(forth_isa_pkg::op_equal);
			put_op(forth_isa_pkg::op_emit);
			r = ref_result(forth_isa_pkg::op_equal, a, b);
			exp_q.push_back(r[7:0]);
			// drop b, test a for zero
			put_operand(forth_isa_pkg::op_lit, a);
			put_operand(forth_isa_pkg::op_lit, b);
			put_op(forth_isa_pkg::op_drop);
			put_op(forth_isa_pkg::op_zero_equal);
			put_op(forth_isa_pkg::op_emit);
			r = ref_result(forth_isa_pkg::op_zero_equal, a, '0);
			exp_q.push_back(r[7:0]);
			put_operand(forth_isa_pkg::op_lit, '0);
			put_op(forth_isa_pkg::op_zero_equal);
			put_op(forth_isa_pkg::op_emit);
			r = ref_result(forth_isa_pkg::op_zero_equal, '0, '0);
			exp_q.push_back(r[7:0]);
			end_in_self_loop();
			start_program(7);
			wait_drained(8 * frame_cycles);
		end

		// --------------------
		// countdown loop, one marker per pass
		loops = 2 + {$random(seed)} % 4;
		mark = 8'($random(seed));
		prog.delete();
		put_operand(forth_isa_pkg::op_lit, forth_isa_pkg::cell_t'(loops));
		// loop top at address 2
		put_operand(forth_isa_pkg::op_lit, forth_isa_pkg::cell_t'(mark));
		put_op(forth_isa_pkg::op_emit);
		put_operand(forth_isa_pkg::op_lit, 32'd1);
		put_op(forth_isa_pkg::op_minus);
		put_op(forth_isa_pkg::op_dup);
		put_op(forth_isa_pkg::op_zero_equal);
		put_operand(forth_isa_pkg::op_zero_branch, 32'd2);
		put_op(forth_isa_pkg::op_drop);
		end_in_self_loop();
		for (int i = 0; i < loops; i++) begin
			exp_q.push_back(mark);
		end
		bytes_seen = 0;
		start_program(loops);
		wait_drained((loops + 1) * frame_cycles);
		check_quiet(3 * frame_cycles);
		assert (bytes_seen == loops)
		else begin
			$display("FAILED marker_count expected %h got %h", loops, bytes_seen);
			errors++;
		end

		// call into a subroutine, the byte order proves the return
		a = $random(seed);
		b = $random(seed);
		prog.delete();
		// call cell patched below
		prog.push_back('0);
		put_operand(forth_isa_pkg::op_lit, b);
		put_op(forth_isa_pkg::op_emit);
		end_in_self_loop();
		sub_addr = prog.size();
		put_operand(forth_isa_pkg::op_lit, a);
		put_op(forth_isa_pkg::op_emit);
		put_op(forth_isa_pkg::op_exit);
		prog[0] = -forth_isa_pkg::cell_t'(sub_addr);
		exp_q.push_back(a[7:0]);
		exp_q.push_back(b[7:0]);
		start_program(2);
		wait_drained(3 * frame_cycles);

		// --------------------
		// key in, emit plus one, led around it
		k = 8'($random(seed));
		prog.delete();
		put_op(forth_isa_pkg::op_led_on);
		put_op(forth_isa_pkg::op_key);
		put_op(forth_isa_pkg::op_one_plus);
		put_op(forth_isa_pkg::op_emit);
		put_op(forth_isa_pkg::op_led_off);
		end_in_self_loop();
		r = ref_result(forth_isa_pkg::op_one_plus, forth_isa_pkg::cell_t'(k), '0);
		exp_q.push_back(r[7:0]);
		start_program(1);
		wait_led(3'd7, 50);
		assert (led == 3'd7)
		else begin
			$display("FAILED led expected %h got %h", 3'd7, led);
			errors++;
		end
		send_byte(k);
		wait_drained(2 * frame_cycles);
		wait_led(3'd0, frame_cycles);
		assert (led == 3'd0)
		else begin
			$display("FAILED led expected %h got %h", 3'd0, led);
			errors++;
		end

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+design
design/forth_isa_pkg.sv
design/forth_io_pkg.sv
design/program_ram.sv
design/forth_core.sv
design/uart_tx.sv
design/uart_rx.sv
design/forth_top.sv
verification/forth_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the stack processor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module forth_tb -o forth_sim

# output goes to the terminal, the pass line decides the status
./obj_dir/forth_sim | tee /dev/stderr | grep -qx "PASS: all tests"
